//--- hdl/access_timer.sv
// Access time model for the scratchpad.
// Loaded on start, counts down and pulses done for one cycle when the
// count reaches zero. Flush abandons a running count.

`timescale 1ns/1ps

module access_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic flush_i,
  input  logic start_i,
  output logic done_o
);

  logic                        busy;
  logic [mem_pkg::TIMER_W-1:0] count;

  assign done_o = busy && (count == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy  <= 1'b0;
      count <= '0;
    end else if (flush_i) begin
      busy  <= 1'b0;
      count <= '0;
    end else if (start_i) begin
      busy  <= 1'b1;
      count <= mem_pkg::TIMER_W'(mem_pkg::ACCESS_CYCLES - 1);
    end else if (busy) begin
      // Stop after the done cycle
      if (count == '0) begin
        busy <= 1'b0;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- hdl/data_ram.sv
// Local data scratchpad with the LL/SC reservation.
// Reads are combinational from the held address; writes and reservation
// updates happen on the commit strobe. Stores write the byte lanes
// picked by size and address, SC writes the whole word when it holds.

`timescale 1ns/1ps

module data_ram (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush_i,
  input  logic                     commit_i,
  input  mem_pkg::mem_op_e         op_i,
  input  mem_pkg::align_e          align_i,
  input  logic [mem_pkg::XLEN-1:0] vaddr_i,
  input  logic [mem_pkg::XLEN-1:0] wdata_i,
  input  logic                     misalign_i,
  output logic [mem_pkg::XLEN-1:0] rdata_o,
  output logic                     sc_ok_o
);

  logic [mem_pkg::XLEN-1:0]   mem [mem_pkg::RAM_WORDS];
  logic [mem_pkg::RAM_AW-1:0] widx;

  logic                       llbit;
  logic [mem_pkg::RAM_AW-1:0] ll_addr;

  logic [mem_pkg::BYTES-1:0]  be;
  logic [mem_pkg::XLEN-1:0]   wword;
  logic                       do_write;
  logic                       do_update;

  assign widx    = vaddr_i[mem_pkg::RAM_AW+1:2];
  assign rdata_o = mem[widx];
  assign sc_ok_o = llbit && (ll_addr == widx);

  // ==================================================
  // Byte lanes
  // ==================================================

  always_comb begin
    be    = '0;
    wword = wdata_i;
    if (op_i == mem_pkg::MEM_SC) begin
      be = '1;
    end else begin
      case (align_i)
        mem_pkg::ALIGN_B, mem_pkg::ALIGN_BU: begin
          be    = mem_pkg::BYTES'(1) << vaddr_i[1:0];
          wword = {mem_pkg::BYTES{wdata_i[7:0]}};
        end
        mem_pkg::ALIGN_H, mem_pkg::ALIGN_HU: begin
          be    = vaddr_i[1] ? 4'b1100 : 4'b0011;
          wword = {2{wdata_i[15:0]}};
        end
        default: be = '1;
      endcase
    end
  end

  assign do_update = commit_i & ~misalign_i;
  assign do_write  = do_update &
                     ((op_i == mem_pkg::MEM_STORE) || (op_i == mem_pkg::MEM_SC && sc_ok_o));

  // ==================================================
  // Storage
  // ==================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < mem_pkg::RAM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (do_write && !flush_i) begin
      for (int b = 0; b < mem_pkg::BYTES; b++) begin
        if (be[b]) begin
          mem[widx][8*b +: 8] <= wword[8*b +: 8];
        end
      end
    end
  end

  // Reservation flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      llbit <= 1'b0;
    end else if (flush_i) begin
      llbit <= 1'b0;
    end else if (do_update) begin
      case (op_i)
        mem_pkg::MEM_LL:    llbit <= 1'b1;
        mem_pkg::MEM_SC:    llbit <= 1'b0;
        // A plain store to the reserved word breaks the link
        mem_pkg::MEM_STORE: if (widx == ll_addr) llbit <= 1'b0;
        default:            llbit <= llbit;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_update && op_i == mem_pkg::MEM_LL) begin
      ll_addr <= widx;
    end
  end

endmodule

//--- hdl/mem_block.sv
// Memory-access stage top level.
// Takes one load, store, LL or SC from execute, accesses the local
// scratchpad after a fixed access time and hands a writeback record
// to the commit side. Only instances and wiring live here.

`timescale 1ns/1ps

module mem_block (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush_i,
  // Execute side
  input  logic                          exe_valid_i,
  output logic                          exe_ready_o,
  input  mem_pkg::mem_op_e              exe_op_i,
  input  mem_pkg::align_e               exe_align_i,
  input  logic [mem_pkg::XLEN-1:0]      exe_base_i,
  input  logic [mem_pkg::IMM_W-1:0]     exe_imm_i,
  input  logic [mem_pkg::XLEN-1:0]      exe_wdata_i,
  input  logic [mem_pkg::ROB_IDX_W-1:0] exe_rob_idx_i,
  input  logic [mem_pkg::PREG_W-1:0]    exe_pdest_i,
  // Writeback side
  output logic                          wb_valid_o,
  input  logic                          wb_ready_i,
  output logic                          wb_we_o,
  output logic [mem_pkg::XLEN-1:0]      wb_wdata_o,
  output logic [mem_pkg::ROB_IDX_W-1:0] wb_rob_idx_o,
  output logic [mem_pkg::PREG_W-1:0]    wb_pdest_o,
  output logic [mem_pkg::XLEN-1:0]      wb_vaddr_o,
  output logic                          wb_excp_o
);

  logic load;
  logic start;
  logic commit;
  logic timer_done;
  logic wb_handshake;

  // Held operation
  mem_pkg::mem_op_e              s_op;
  mem_pkg::align_e               s_align;
  logic [mem_pkg::XLEN-1:0]      s_vaddr;
  logic [mem_pkg::XLEN-1:0]      s_wdata;
  logic [mem_pkg::ROB_IDX_W-1:0] s_rob_idx;
  logic [mem_pkg::PREG_W-1:0]    s_pdest;
  logic                          s_misalign;

  logic [mem_pkg::XLEN-1:0]      ram_rdata;
  logic                          sc_ok;

  assign wb_handshake = wb_valid_o & wb_ready_i;

  mem_ctrl_fsm u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .exe_valid_i  (exe_valid_i),
    .exe_ready_o  (exe_ready_o),
    .wb_ready_i   (wb_ready_i),
    .timer_done_i (timer_done),
    .load_o       (load),
    .start_o      (start),
    .commit_o     (commit),
    .wb_valid_o   (wb_valid_o)
  );

  access_timer u_timer (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (flush_i),
    .start_i (start),
    .done_o  (timer_done)
  );

  mem_stage_reg u_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .load_i        (load),
    .exe_op_i      (exe_op_i),
    .exe_align_i   (exe_align_i),
    .exe_base_i    (exe_base_i),
    .exe_imm_i     (exe_imm_i),
    .exe_wdata_i   (exe_wdata_i),
    .exe_rob_idx_i (exe_rob_idx_i),
    .exe_pdest_i   (exe_pdest_i),
    .op_o          (s_op),
    .align_o       (s_align),
    .vaddr_o       (s_vaddr),
    .wdata_o       (s_wdata),
    .rob_idx_o     (s_rob_idx),
    .pdest_o       (s_pdest),
    .misalign_o    (s_misalign)
  );

  data_ram u_ram (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .commit_i   (commit),
    .op_i       (s_op),
    .align_i    (s_align),
    .vaddr_i    (s_vaddr),
    .wdata_i    (s_wdata),
    .misalign_i (s_misalign),
    .rdata_o    (ram_rdata),
    .sc_ok_o    (sc_ok)
  );

  wb_former u_wb (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush_i        (flush_i),
    .commit_i       (commit),
    .wb_handshake_i (wb_handshake),
    .op_i           (s_op),
    .align_i        (s_align),
    .vaddr_i        (s_vaddr),
    .rob_idx_i      (s_rob_idx),
    .pdest_i        (s_pdest),
    .misalign_i     (s_misalign),
    .rdata_i        (ram_rdata),
    .sc_ok_i        (sc_ok),
    .wb_we_o        (wb_we_o),
    .wb_wdata_o     (wb_wdata_o),
    .wb_rob_idx_o   (wb_rob_idx_o),
    .wb_pdest_o     (wb_pdest_o),
    .wb_vaddr_o     (wb_vaddr_o),
    .wb_excp_o      (wb_excp_o)
  );

endmodule

//--- hdl/mem_ctrl_fsm.sv
// Sequencer for the memory stage.
// Accepts one operation at a time, waits for the access timer, then
// holds the result until the writeback side takes it. A new operation
// can be accepted in the same cycle the previous result leaves.

`timescale 1ns/1ps

module mem_ctrl_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic flush_i,
  input  logic exe_valid_i,
  output logic exe_ready_o,
  input  logic wb_ready_i,
  input  logic timer_done_i,
  output logic load_o,
  output logic start_o,
  output logic commit_o,
  output logic wb_valid_o
);

  mem_pkg::fsm_state_e state;
  mem_pkg::fsm_state_e state_nxt;

  logic accept;

  // ==================================================
  // Handshakes
  // ==================================================

  // Free when idle, or when the held result leaves this cycle
  assign exe_ready_o = (state == mem_pkg::IDLE) ||
                       (state == mem_pkg::RESP && wb_ready_i);

  // Flush kills anything arriving in the same cycle
  assign accept = exe_valid_i & exe_ready_o & ~flush_i;

  assign load_o = accept;

  // Timer runs from the accept edge
  assign start_o = accept;

  // Write and result capture on the last access cycle
  assign commit_o = (state == mem_pkg::ACCESS) & timer_done_i & ~flush_i;

  assign wb_valid_o = (state == mem_pkg::RESP);

  // ==================================================
  // State register
  // ==================================================

  always_comb begin
    state_nxt = state;
    case (state)
      mem_pkg::IDLE: begin
        if (accept) begin
          state_nxt = mem_pkg::ACCESS;
        end
      end
      mem_pkg::ACCESS: begin
        if (timer_done_i) begin
          state_nxt = mem_pkg::RESP;
        end
      end
      mem_pkg::RESP: begin
        // Back-pressure keeps us here with the record stable
        if (wb_ready_i) begin
          state_nxt = accept ? mem_pkg::ACCESS : mem_pkg::IDLE;
        end
      end
      default: begin
        state_nxt = mem_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= mem_pkg::IDLE;
    end else if (flush_i) begin
      state <= mem_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

//--- hdl/mem_pkg.sv
// Shared encodings and sizes for the memory-access stage.
// Every stage module refers to these through mem_pkg:: scoped names,
// so this package must be compiled before any of them.

package mem_pkg;

  // ==================================================
  // Widths
  // ==================================================

  // Data and address width
  localparam int XLEN = 32;

  // Immediate from execute, sign-extended before the add
  localparam int IMM_W = 12;

  localparam int ROB_IDX_W = 6;
  localparam int PREG_W = 6;

  // Byte lanes per data word
  localparam int BYTES = XLEN / 8;

  // ==================================================
  // Scratchpad
  // ==================================================

  // Word address width, upper address bits are ignored
  localparam int RAM_AW = 8;
  localparam int RAM_WORDS = 1 << RAM_AW;

  // Fixed access time of the scratchpad, in cycles
  localparam int ACCESS_CYCLES = 2;

  // Counter width wide enough to hold ACCESS_CYCLES - 1
  localparam int TIMER_W = $clog2(ACCESS_CYCLES + 1);

  // ==================================================
  // Encodings
  // ==================================================

  typedef enum logic [1:0] {
    MEM_LOAD  = 2'd0,
    MEM_STORE = 2'd1,
    MEM_LL    = 2'd2,
    MEM_SC    = 2'd3
  } mem_op_e;

  // Access size, U variants zero-extend on load
  typedef enum logic [2:0] {
    ALIGN_B  = 3'd0,
    ALIGN_BU = 3'd1,
    ALIGN_H  = 3'd2,
    ALIGN_HU = 3'd3,
    ALIGN_W  = 3'd4
  } align_e;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    ACCESS = 2'd1,
    RESP   = 2'd2
  } fsm_state_e;

endpackage

//--- hdl/mem_stage_reg.sv
// Operation register of the memory stage.
// Captures the accepted operation, forms the address as base plus the
// sign-extended immediate and flags misaligned accesses. Fields hold
// until the next load.

`timescale 1ns/1ps

module mem_stage_reg (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush_i,
  input  logic                          load_i,
  input  mem_pkg::mem_op_e              exe_op_i,
  input  mem_pkg::align_e               exe_align_i,
  input  logic [mem_pkg::XLEN-1:0]      exe_base_i,
  input  logic [mem_pkg::IMM_W-1:0]     exe_imm_i,
  input  logic [mem_pkg::XLEN-1:0]      exe_wdata_i,
  input  logic [mem_pkg::ROB_IDX_W-1:0] exe_rob_idx_i,
  input  logic [mem_pkg::PREG_W-1:0]    exe_pdest_i,
  output mem_pkg::mem_op_e              op_o,
  output mem_pkg::align_e               align_o,
  output logic [mem_pkg::XLEN-1:0]      vaddr_o,
  output logic [mem_pkg::XLEN-1:0]      wdata_o,
  output logic [mem_pkg::ROB_IDX_W-1:0] rob_idx_o,
  output logic [mem_pkg::PREG_W-1:0]    pdest_o,
  output logic                          misalign_o
);

  logic [mem_pkg::XLEN-1:0] imm_ext;
  logic [mem_pkg::XLEN-1:0] addr;
  logic                     misalign;

  // ==================================================
  // Address generation
  // ==================================================

  assign imm_ext = {{(mem_pkg::XLEN - mem_pkg::IMM_W){exe_imm_i[mem_pkg::IMM_W-1]}},
                    exe_imm_i};
  assign addr = exe_base_i + imm_ext;

  always_comb begin
    misalign = 1'b0;
    if (exe_op_i == mem_pkg::MEM_LL || exe_op_i == mem_pkg::MEM_SC) begin
      // Atomics are always word sized
      misalign = (addr[1:0] != 2'b00);
    end else begin
      case (exe_align_i)
        mem_pkg::ALIGN_H, mem_pkg::ALIGN_HU: misalign = addr[0];
        mem_pkg::ALIGN_W:                    misalign = (addr[1:0] != 2'b00);
        default:                             misalign = 1'b0;
      endcase
    end
  end

  // ==================================================
  // Registers
  // ==================================================

  // Control fields, flush returns them to a harmless load
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_o       <= mem_pkg::MEM_LOAD;
      align_o    <= mem_pkg::ALIGN_W;
      misalign_o <= 1'b0;
    end else if (flush_i) begin
      op_o       <= mem_pkg::MEM_LOAD;
      align_o    <= mem_pkg::ALIGN_W;
      misalign_o <= 1'b0;
    end else if (load_i) begin
      op_o       <= exe_op_i;
      align_o    <= exe_align_i;
      misalign_o <= misalign;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (load_i) begin
      vaddr_o   <= addr;
      wdata_o   <= exe_wdata_i;
      rob_idx_o <= exe_rob_idx_i;
      pdest_o   <= exe_pdest_i;
    end
  end

endmodule

//--- hdl/wb_former.sv
// Writeback record builder.
// Picks the loaded lane, sign- or zero-extends it, substitutes the SC
// result where needed and registers the record on commit. The record
// then stays stable until the writeback handshake.

`timescale 1ns/1ps

module wb_former (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush_i,
  input  logic                          commit_i,
  input  logic                          wb_handshake_i,
  input  mem_pkg::mem_op_e              op_i,
  input  mem_pkg::align_e               align_i,
  input  logic [mem_pkg::XLEN-1:0]      vaddr_i,
  input  logic [mem_pkg::ROB_IDX_W-1:0] rob_idx_i,
  input  logic [mem_pkg::PREG_W-1:0]    pdest_i,
  input  logic                          misalign_i,
  input  logic [mem_pkg::XLEN-1:0]      rdata_i,
  input  logic                          sc_ok_i,
  output logic                          wb_we_o,
  output logic [mem_pkg::XLEN-1:0]      wb_wdata_o,
  output logic [mem_pkg::ROB_IDX_W-1:0] wb_rob_idx_o,
  output logic [mem_pkg::PREG_W-1:0]    wb_pdest_o,
  output logic [mem_pkg::XLEN-1:0]      wb_vaddr_o,
  output logic                          wb_excp_o
);

  logic [7:0]               byte_lane;
  logic [15:0]              half_lane;
  logic [mem_pkg::XLEN-1:0] load_val;
  logic [mem_pkg::XLEN-1:0] result;
  logic                     we;

  // Lane select by low address bits
  assign byte_lane = rdata_i[8*vaddr_i[1:0] +: 8];
  assign half_lane = vaddr_i[1] ? rdata_i[31:16] : rdata_i[15:0];

  always_comb begin
    case (align_i)
      mem_pkg::ALIGN_B:  load_val = {{24{byte_lane[7]}}, byte_lane};
      mem_pkg::ALIGN_BU: load_val = {24'd0, byte_lane};
      mem_pkg::ALIGN_H:  load_val = {{16{half_lane[15]}}, half_lane};
      mem_pkg::ALIGN_HU: load_val = {16'd0, half_lane};
      default:           load_val = rdata_i;
    endcase
  end

  // LL returns the whole word, SC returns the reservation outcome
  always_comb begin
    case (op_i)
      mem_pkg::MEM_LL: result = rdata_i;
      mem_pkg::MEM_SC: result = {{(mem_pkg::XLEN-1){1'b0}}, sc_ok_i};
      default:         result = load_val;
    endcase
  end

  assign we = ~misalign_i & (op_i != mem_pkg::MEM_STORE);

  // ==================================================
  // Result register
  // ==================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_o   <= 1'b0;
      wb_excp_o <= 1'b0;
    end else if (flush_i) begin
      wb_we_o   <= 1'b0;
      wb_excp_o <= 1'b0;
    end else if (commit_i) begin
      wb_we_o   <= we;
      wb_excp_o <= misalign_i;
    end else if (wb_handshake_i) begin
      // Record consumed
      wb_we_o   <= 1'b0;
      wb_excp_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (commit_i) begin
      wb_wdata_o   <= result;
      wb_rob_idx_o <= rob_idx_i;
      wb_pdest_o   <= pdest_i;
      wb_vaddr_o   <= vaddr_i;
    end
  end

endmodule

//--- mem_block.f
hdl/mem_pkg.sv
hdl/access_timer.sv
hdl/mem_ctrl_fsm.sv
hdl/mem_stage_reg.sv
hdl/data_ram.sv
hdl/wb_former.sv
hdl/mem_block.sv
verification/mem_block_tb.sv

//--- run.sh
#!/bin/sh
# Builds the memory stage testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module mem_block_tb \
  -f mem_block.f -Mdir obj_dir -o mem_block_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mem_block_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
  exit 0
fi
exit 1

//--- verification/mem_block_tb.sv
// Testbench for the memory-access stage.
// Applies a table of loads, stores, LL and SC operations, then a run of
// xorshift-generated operations, and checks every writeback record
// against a byte-array reference model with its own reservation flag.

`timescale 1ns/1ps

module mem_block_tb;

  localparam int MAX_ROWS = 32;
  localparam int NRAND    = 40;
  localparam int TIMEOUT  = 20;

  logic                     clk;
  logic                     rst_n;
  logic                     flush_i;
  logic                     exe_valid_i;
  logic                     exe_ready_o;
  mem_pkg::mem_op_e         exe_op_i;
  mem_pkg::align_e          exe_align_i;
  logic [31:0]              exe_base_i;
  logic [11:0]              exe_imm_i;
  logic [31:0]              exe_wdata_i;
  logic [5:0]               exe_rob_idx_i;
  logic [5:0]               exe_pdest_i;
  logic                     wb_valid_o;
  logic                     wb_ready_i;
  logic                     wb_we_o;
  logic [31:0]              wb_wdata_o;
  logic [5:0]               wb_rob_idx_o;
  logic [5:0]               wb_pdest_o;
  logic [31:0]              wb_vaddr_o;
  logic                     wb_excp_o;

  // Stimulus table
  mem_pkg::mem_op_e         t_op    [MAX_ROWS];
  mem_pkg::align_e          t_align [MAX_ROWS];
  logic [31:0]              t_base  [MAX_ROWS];
  logic [11:0]              t_imm   [MAX_ROWS];
  logic [31:0]              t_wdata [MAX_ROWS];
  logic [5:0]               t_pdest [MAX_ROWS];
  int                       t_hold  [MAX_ROWS];
  logic                     t_flush [MAX_ROWS];
  logic                     t_chain [MAX_ROWS];
  int                       n_rows;

  // Reference model, byte addressed over the 1 KiB scratchpad
  logic [7:0]               ref_mem [1024];
  logic                     ref_llbit;
  logic [7:0]               ref_ll_word;

  logic [31:0]              rng;

  mem_block UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .exe_valid_i   (exe_valid_i),
    .exe_ready_o   (exe_ready_o),
    .exe_op_i      (exe_op_i),
    .exe_align_i   (exe_align_i),
    .exe_base_i    (exe_base_i),
    .exe_imm_i     (exe_imm_i),
    .exe_wdata_i   (exe_wdata_i),
    .exe_rob_idx_i (exe_rob_idx_i),
    .exe_pdest_i   (exe_pdest_i),
    .wb_valid_o    (wb_valid_o),
    .wb_ready_i    (wb_ready_i),
    .wb_we_o       (wb_we_o),
    .wb_wdata_o    (wb_wdata_o),
    .wb_rob_idx_o  (wb_rob_idx_o),
    .wb_pdest_o    (wb_pdest_o),
    .wb_vaddr_o    (wb_vaddr_o),
    .wb_excp_o     (wb_excp_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==================================================
  // Helpers
  // ==================================================

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic timed_out(input string what);
    $display("timeout while waiting for %s", what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic add_row(input mem_pkg::mem_op_e op, input mem_pkg::align_e align,
                         input logic [31:0] base, input logic [11:0] imm,
                         input logic [31:0] wdata, input logic [5:0] pdest,
                         input int hold, input logic flush);
    t_op[n_rows]    = op;
    t_align[n_rows] = align;
    t_base[n_rows]  = base;
    t_imm[n_rows]   = imm;
    t_wdata[n_rows] = wdata;
    t_pdest[n_rows] = pdest;
    t_hold[n_rows]  = hold;
    t_flush[n_rows] = flush;
    t_chain[n_rows] = 1'b0;
    n_rows++;
  endtask

  // ==================================================
  // Reference model
  // ==================================================

  function automatic logic misaligned(input mem_pkg::mem_op_e op, input mem_pkg::align_e align,
                                      input logic [31:0] a);
    if (op == mem_pkg::MEM_LL || op == mem_pkg::MEM_SC) begin
      return a[1:0] != 2'b00;
    end
    if (align == mem_pkg::ALIGN_H || align == mem_pkg::ALIGN_HU) begin
      return a[0];
    end
    if (align == mem_pkg::ALIGN_W) begin
      return a[1:0] != 2'b00;
    end
    return 1'b0;
  endfunction

  // Computes the expected record and applies the operation to the model
  task automatic predict(input mem_pkg::mem_op_e op, input mem_pkg::align_e align,
                         input logic [31:0] vaddr, input logic [31:0] wdata,
                         output logic we, output logic excp, output logic [31:0] val);
    logic [9:0]  a;
    logic [9:0]  w;
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] word;
    logic        ok;
    a    = vaddr[9:0];
    w    = {a[9:2], 2'b00};
    b    = ref_mem[a];
    h    = {ref_mem[{a[9:1], 1'b1}], ref_mem[{a[9:1], 1'b0}]};
    word = {ref_mem[w + 3], ref_mem[w + 2], ref_mem[w + 1], ref_mem[w]};
    ok   = ref_llbit && (ref_ll_word == a[9:2]);
    excp = misaligned(op, align, vaddr);
    we   = !excp && (op != mem_pkg::MEM_STORE);
    case (align)
      mem_pkg::ALIGN_B:  val = {{24{b[7]}}, b};
      mem_pkg::ALIGN_BU: val = {24'd0, b};
      mem_pkg::ALIGN_H:  val = {{16{h[15]}}, h};
      mem_pkg::ALIGN_HU: val = {16'd0, h};
      default:           val = word;
    endcase
    if (op == mem_pkg::MEM_LL) begin
      val = word;
    end
    if (op == mem_pkg::MEM_SC) begin
      val = {31'd0, ok};
    end
    if (!excp) begin
      case (op)
        mem_pkg::MEM_LL: begin
          ref_llbit   = 1'b1;
          ref_ll_word = a[9:2];
        end
        mem_pkg::MEM_SC: begin
          if (ok) begin
            for (int k = 0; k < 4; k++) ref_mem[w + k] = wdata[8*k +: 8];
          end
          ref_llbit = 1'b0;
        end
        mem_pkg::MEM_STORE: begin
          if (align == mem_pkg::ALIGN_B || align == mem_pkg::ALIGN_BU) begin
            ref_mem[a] = wdata[7:0];
          end else if (align == mem_pkg::ALIGN_H || align == mem_pkg::ALIGN_HU) begin
            ref_mem[{a[9:1], 1'b0}] = wdata[7:0];
            ref_mem[{a[9:1], 1'b1}] = wdata[15:8];
          end else begin
            for (int k = 0; k < 4; k++) ref_mem[w + k] = wdata[8*k +: 8];
          end
          if (ref_llbit && ref_ll_word == a[9:2]) ref_llbit = 1'b0;
        end
        default: ;
      endcase
    end
  endtask

  // ==================================================
  // One operation through the stage
  // ==================================================

  task automatic run_op(input mem_pkg::mem_op_e op, input mem_pkg::align_e align,
                        input logic [31:0] base, input logic [11:0] imm,
                        input logic [31:0] wdata, input logic [5:0] pdest,
                        input int hold, input logic flush, input logic chain,
                        input logic [5:0] rob);
    logic [31:0] vaddr;
    logic        exp_we;
    logic        exp_excp;
    logic [31:0] exp_val;
    int          cycles;
    vaddr = base + {{20{imm[11]}}, imm};
    exe_valid_i   = 1'b1;
    exe_op_i      = op;
    exe_align_i   = align;
    exe_base_i    = base;
    exe_imm_i     = imm;
    exe_wdata_i   = wdata;
    exe_rob_idx_i = rob;
    exe_pdest_i   = pdest;
    #1;
    // Free when idle, or in the cycle a chained result leaves
    check("exe_ready_o", 32'(exe_ready_o), 32'd1);
    next_cycle();
    exe_valid_i = 1'b0;
    wb_ready_i  = (hold == 0);
    cycles      = 1;
    if (flush) begin
      // Kill the operation while the access is still running
      check("wb_valid_o", 32'(wb_valid_o), 32'd0);
      flush_i = 1'b1;
      next_cycle();
      flush_i   = 1'b0;
      ref_llbit = 1'b0;
      check("exe_ready_o", 32'(exe_ready_o), 32'd1);
      for (int i = 0; i < 4; i++) begin
        check("wb_valid_o", 32'(wb_valid_o), 32'd0);
        next_cycle();
      end
      wb_ready_i = 1'b1;
    end else begin
      predict(op, align, vaddr, wdata, exp_we, exp_excp, exp_val);
      while (!wb_valid_o) begin
        check("exe_ready_o", 32'(exe_ready_o), 32'd0);
        if (cycles >= TIMEOUT) begin
          timed_out("wb_valid_o");
        end
        next_cycle();
        cycles++;
      end
      check("latency", 32'(cycles), 32'd3);
      for (int i = 0; i <= hold; i++) begin
        check("wb_valid_o", 32'(wb_valid_o), 32'd1);
        check("wb_excp_o", 32'(wb_excp_o), 32'(exp_excp));
        check("wb_we_o", 32'(wb_we_o), 32'(exp_we));
        if (exp_we) begin
          check("wb_wdata_o", wb_wdata_o, exp_val);
        end
        check("wb_vaddr_o", wb_vaddr_o, vaddr);
        check("wb_rob_idx_o", 32'(wb_rob_idx_o), 32'(rob));
        check("wb_pdest_o", 32'(wb_pdest_o), 32'(pdest));
        if (i < hold) begin
          // Back-pressure blocks new work
          check("exe_ready_o", 32'(exe_ready_o), 32'd0);
          next_cycle();
        end
      end
      wb_ready_i = 1'b1;
      if (!chain) begin
        // Result leaves with no new work behind it
        #1;
        check("exe_ready_o", 32'(exe_ready_o), 32'd1);
        next_cycle();
        check("wb_valid_o", 32'(wb_valid_o), 32'd0);
      end
    end
  endtask

  // ==================================================
  // Main sequence
  // ==================================================

  initial begin
    logic [31:0]      r;
    logic [31:0]      d;
    logic [2:0]       a3;
    rst_n         = 1'b0;
    flush_i       = 1'b0;
    exe_valid_i   = 1'b0;
    exe_op_i      = mem_pkg::MEM_LOAD;
    exe_align_i   = mem_pkg::ALIGN_W;
    exe_base_i    = '0;
    exe_imm_i     = '0;
    exe_wdata_i   = '0;
    exe_rob_idx_i = '0;
    exe_pdest_i   = '0;
    wb_ready_i    = 1'b1;
    rng           = 32'd51;
    n_rows        = 0;
    ref_llbit     = 1'b0;
    ref_ll_word   = '0;
    for (int i = 0; i < 1024; i++) ref_mem[i] = 8'h00;

    // Sized stores followed by signed and unsigned loads
    add_row(mem_pkg::MEM_STORE, mem_pkg::ALIGN_W,  32'h40, 12'h000, 32'h89ab_cdef, 6'd1, 0, 0);
    // Next row is accepted in the cycle this result leaves
    t_chain[n_rows - 1] = 1'b1;
    add_row(mem_pkg::MEM_LOAD,  mem_pkg::ALIGN_W,  32'h40, 12'h000, 32'h0,         6'd2, 0, 0);
    add_row(mem_pkg::MEM_STORE, mem_pkg::ALIGN_B,  32'h40, 12'h001, 32'h0000_00f5, 6'd3, 0, 0);
    add_row(mem_pkg::MEM_LOAD,  mem_pkg::ALIGN_B,  32'h40, 12'h001, 32'h0,         6'd4, 0, 0);
    add_row(mem_pkg::MEM_LOAD,  mem_pkg::ALIGN_BU, 32'h40, 12'h001, 32'h0,         6'd5, 0, 0);
    add_row(mem_pkg::MEM_STORE, mem_pkg::ALIGN_H,  32'h44, 12'hffe, 32'h0000_8001, 6'd6, 0, 0);
    add_row(mem_pkg::MEM_LOAD,  mem_pkg::ALIGN_H,  32'h42, 12'h000, 32'h0,         6'd7, 0, 0);
    add_row(mem_pkg::MEM_LOAD,  mem_pkg::ALIGN_HU, 32'h42, 12'h000, 32'h0,         6'd8, 3, 0);
    t_chain[n_rows - 1] = 1'b1;
    add_row(mem_pkg::MEM_LOAD,  mem_pkg::ALIGN_W,  32'h40, 12'h000, 32'h0,         6'd9, 0, 0);
    add_row(mem_pkg::MEM_LOAD,  mem_pkg::ALIGN_BU, 32'h8000_0040, 12'h003, 32'h0,  6'd10, 0, 0);
    // Misaligned accesses
    add_row(mem_pkg::MEM_STORE, mem_pkg::ALIGN_H,  32'h45, 12'h000, 32'h0000_1234, 6'd11, 0, 0);
    add_row(mem_pkg::MEM_STORE, mem_pkg::ALIGN_W,  32'h46, 12'h000, 32'h5555_aaaa, 6'd12, 0, 0);
    add_row(mem_pkg::MEM_LOAD,  mem_pkg::ALIGN_W,  32'h44, 12'h000, 32'h0,         6'd13, 0, 0);
    add_row(mem_pkg::MEM_LOAD,  mem_pkg::ALIGN_H,  32'h43, 12'h000, 32'h0,         6'd14, 1, 0);
    // LL/SC reservation
    add_row(mem_pkg::MEM_SC,    mem_pkg::ALIGN_W,  32'h50, 12'h000, 32'h1111_1111, 6'd15, 0, 0);
    add_row(mem_pkg::MEM_LOAD,  mem_pkg::ALIGN_W,  32'h50, 12'h000, 32'h0,         6'd16, 0, 0);
    add_row(mem_pkg::MEM_LL,    mem_pkg::ALIGN_W,  32'h50, 12'h000, 32'h0,         6'd17, 0, 0);
    add_row(mem_pkg::MEM_SC,    mem_pkg::ALIGN_W,  32'h50, 12'h000, 32'h1234_5678, 6'd18, 0, 0);
    t_chain[n_rows - 1] = 1'b1;
    add_row(mem_pkg::MEM_LOAD,  mem_pkg::ALIGN_W,  32'h50, 12'h000, 32'h0,         6'd19, 0, 0);
    add_row(mem_pkg::MEM_LL,    mem_pkg::ALIGN_W,  32'h50, 12'h000, 32'h0,         6'd20, 0, 0);
    add_row(mem_pkg::MEM_STORE, mem_pkg::ALIGN_W,  32'h50, 12'h000, 32'haaaa_5555, 6'd21, 0, 0);
    add_row(mem_pkg::MEM_SC,    mem_pkg::ALIGN_W,  32'h50, 12'h000, 32'h2222_2222, 6'd22, 0, 0);
    add_row(mem_pkg::MEM_LL,    mem_pkg::ALIGN_W,  32'h50, 12'h000, 32'h0,         6'd23, 0, 0);
    add_row(mem_pkg::MEM_SC,    mem_pkg::ALIGN_W,  32'h54, 12'h000, 32'h3333_3333, 6'd24, 0, 0);
    add_row(mem_pkg::MEM_LL,    mem_pkg::ALIGN_W,  32'h52, 12'h000, 32'h0,         6'd25, 0, 0);
    // Flush drops the store and the reservation
    add_row(mem_pkg::MEM_LL,    mem_pkg::ALIGN_W,  32'h50, 12'h000, 32'h0,         6'd26, 0, 0);
    add_row(mem_pkg::MEM_STORE, mem_pkg::ALIGN_W,  32'h50, 12'h000, 32'hdead_beef, 6'd27, 0, 1);
    add_row(mem_pkg::MEM_LOAD,  mem_pkg::ALIGN_W,  32'h50, 12'h000, 32'h0,         6'd28, 0, 0);
    add_row(mem_pkg::MEM_SC,    mem_pkg::ALIGN_W,  32'h50, 12'h000, 32'h4444_4444, 6'd29, 0, 0);
    add_row(mem_pkg::MEM_LOAD,  mem_pkg::ALIGN_W,  32'h50, 12'h000, 32'h0,         6'd30, 0, 0);

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check("exe_ready_o", 32'(exe_ready_o), 32'd1);
    check("wb_valid_o", 32'(wb_valid_o), 32'd0);

    for (int i = 0; i < n_rows; i++) begin
      run_op(t_op[i], t_align[i], t_base[i], t_imm[i], t_wdata[i], t_pdest[i],
             t_hold[i], t_flush[i], t_chain[i], 6'(i));
    end

    // Random operations over a small window so loads hit earlier stores
    for (int i = 0; i < NRAND; i++) begin
      r   = xorshift(rng);
      d   = xorshift(r);
      rng = d;
      a3  = 3'(r[4:2] % 3'd5);
      run_op(mem_pkg::mem_op_e'(r[1:0]), mem_pkg::align_e'(a3), 32'h100 + 32'(r[13:8]),
             12'h000, d, 6'(r[21:16]), (r[15:14] == 2'b00) ? 1 : 0, 1'b0, 1'b0,
             6'(i + 32));
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule
